// ==== logic/gfx_pkg.sv ====
// gfx pixel path shared types
// apb request and response, live configuration, framebuffer write
// and the memory word union read as bytes, halves or a full word
package gfx_pkg;

  // host to slave, 43 bits
  typedef struct packed {
    logic [7:0]  paddr;   // byte offset of the register
    logic        psel;
    logic        penable; // high from the first access cycle on
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  // slave to host, 34 bits
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;  // ends the transfer
    logic        pslverr; // unmapped offset
  } apb_rsp_t;

  // live pixel configuration, 66 bits
  typedef struct packed {
    logic [1:0]  depth;   // color depth code
    logic [15:0] base;    // framebuffer base word
    logic [15:0] width;   // line width in pixels
    logic [15:0] x;
    logic [15:0] y;
  } pixel_cfg_t;

  // one framebuffer word, lane 0 sits in the top byte
  typedef union packed {
    logic [3:0][7:0]  byte_v; // byte_v[3] is lane 0
    logic [1:0][15:0] half_v; // half_v[1] is the upper half
    logic [31:0]      word_v;
  } mem_word_u;

  // framebuffer write, 53 bits
  typedef struct packed {
    logic [15:0] addr;    // word address
    mem_word_u   data;    // lane placed pixel
    logic [3:0]  sel;     // byte enables, sel[3] is lane 0
    logic        we;
  } mem_wr_t;

  // depth codes, code 3 acts as 32 bit
  localparam logic [1:0] DEPTH_8  = 2'd0;
  localparam logic [1:0] DEPTH_16 = 2'd1;
  localparam logic [1:0] DEPTH_32 = 2'd2;

  // register map
  localparam logic [7:0] REG_CTRL  = 8'h00; // [1:0] depth, [2] auto increment
  localparam logic [7:0] REG_BASE  = 8'h04; // [15:0] base word
  localparam logic [7:0] REG_WIDTH = 8'h08; // [15:0] pixels per line
  localparam logic [7:0] REG_POS   = 8'h0C; // [15:0] x, [31:16] y
  localparam logic [7:0] REG_PIXEL = 8'h10; // pixel data port

endpackage

// ==== logic/pixel_regs.sv ====
// pixel path register block
// apb slave with ctrl, base, width and pos, a write port that turns
// pixel writes into framebuffer writes, and a read port with one wait state
module pixel_regs import gfx_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  apb_req_t    apb_req_i,
  output apb_rsp_t    apb_rsp_o,
  output pixel_cfg_t  cfg_o,
  input  logic [15:0] word_addr_i, // from pixel_addr
  input  logic [1:0]  lane_i,
  output logic [31:0] color_o,     // to color_to_memory
  input  mem_word_u   mem_word_i,
  input  logic [3:0]  sel_i,
  output mem_wr_t     mem_wr_o,
  output logic        rd_en_o,     // ram read strobe
  output logic [1:0]  rd_lane_o,
  input  logic [31:0] pixel_i      // from memory_to_color
);

  logic [2:0]  ctrl_q;     // autoinc, depth
  logic [15:0] base_q;
  logic [15:0] width_q;
  logic [15:0] x_q;
  logic [15:0] y_q;
  logic        rd_pend_q;  // ram word arrives this cycle
  logic [1:0]  rd_lane_q;
  logic        access;
  logic        is_pix;
  logic        pix_rd;
  logic        mapped;
  logic        done;
  logic [31:0] rd_data;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign is_pix = apb_req_i.paddr == REG_PIXEL;
  assign pix_rd = access & is_pix & ~apb_req_i.pwrite; // needs the wait state
  assign mapped = apb_req_i.paddr inside {REG_CTRL, REG_BASE, REG_WIDTH, REG_POS, REG_PIXEL};
  assign done   = access & apb_rsp_o.pready;           // completing edge

  // ram read goes out in the first access cycle only
  assign rd_en_o   = pix_rd & ~rd_pend_q;
  assign rd_lane_o = rd_lane_q;

  // pixel write lands at the end of its access cycle
  assign color_o        = apb_req_i.pwdata;
  assign mem_wr_o.addr  = word_addr_i;
  assign mem_wr_o.data  = mem_word_i;
  assign mem_wr_o.sel   = sel_i;
  assign mem_wr_o.we    = access & is_pix & apb_req_i.pwrite;

  assign cfg_o.depth = ctrl_q[1:0];
  assign cfg_o.base  = base_q;
  assign cfg_o.width = width_q;
  assign cfg_o.x     = x_q;
  assign cfg_o.y     = y_q;

  always_comb begin
    case (apb_req_i.paddr)
      REG_CTRL:  rd_data = {29'h0, ctrl_q};
      REG_BASE:  rd_data = {16'h0, base_q};
      REG_WIDTH: rd_data = {16'h0, width_q};
      REG_POS:   rd_data = {y_q, x_q};
      REG_PIXEL: rd_data = pixel_i;   // valid in the second access cycle
      default:   rd_data = '0;        // unmapped reads as zero
    endcase
  end

  assign apb_rsp_o.prdata  = rd_data;
  assign apb_rsp_o.pready  = access & (~pix_rd | rd_pend_q);
  assign apb_rsp_o.pslverr = access & ~mapped;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q    <= '0;
      base_q    <= '0;
      width_q   <= '0;
      x_q       <= '0;
      y_q       <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= rd_en_o; // one wait state
      if (done && apb_req_i.pwrite) begin
        case (apb_req_i.paddr)
          REG_CTRL:  ctrl_q  <= apb_req_i.pwdata[2:0];
          REG_BASE:  base_q  <= apb_req_i.pwdata[15:0];
          REG_WIDTH: width_q <= apb_req_i.pwdata[15:0];
          REG_POS: begin
            x_q <= apb_req_i.pwdata[15:0];
            y_q <= apb_req_i.pwdata[31:16];
          end
          default: ; // pixel port or unmapped
        endcase
      end
      if (done && is_pix && ctrl_q[2])
        x_q <= x_q + 16'd1; // auto increment
    end
  end

  // lane of the word in flight
  always_ff @(posedge clk_i) begin
    if (rd_en_o)
      rd_lane_q <= lane_i;
  end

  // an access cycle always follows a setup or access cycle
  a_pready_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_rsp_o.pready |-> $past(apb_req_i.psel));

  a_rd_one_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_en_o |=> apb_rsp_o.pready);

endmodule

// ==== logic/pixel_addr.sv ====
// pixel address unit
// index = y * width + x, scaled to bytes by the depth, then split into
// a framebuffer word address relative to base and a byte lane
module pixel_addr import gfx_pkg::*; #(
  parameter int MEM_AW = 10 // ram address width
) (
  input  pixel_cfg_t  cfg_i,
  output logic [15:0] word_addr_o, // zero above MEM_AW
  output logic [1:0]  lane_o
);

  logic [31:0] pix_idx;   // pixel index in the frame
  logic [1:0]  shift;     // log2 bytes per pixel
  logic [33:0] byte_off;  // byte offset from base
  logic [31:0] word_sum;  // base plus word offset

  // largest index is 65535 * 65535 + 65535, fits 32 bits
  assign pix_idx = 32'(cfg_i.y) * 32'(cfg_i.width) + 32'(cfg_i.x);

  always_comb begin
    case (cfg_i.depth)
      DEPTH_8:  shift = 2'd0;
      DEPTH_16: shift = 2'd1;
      DEPTH_32: shift = 2'd2;
      default:  shift = 2'd2; // code 3 treated as 32 bit
    endcase
  end

  assign byte_off = {2'b00, pix_idx} << shift;

  // base is in words, so only the word part of the offset adds in
  assign word_sum = 32'(cfg_i.base) + byte_off[33:2];

  assign word_addr_o = 16'(word_sum[MEM_AW-1:0]); // wraps inside the ram
  assign lane_o      = byte_off[1:0];             // 0 or 2 at 16 bit, 0 at 32 bit

endmodule

// ==== logic/color_to_memory.sv ====
// color to memory lane placement
// puts the low 8, 16 or 32 bits of a color into the big endian lane
// given by the byte offset and raises the matching byte selects
module color_to_memory import gfx_pkg::*; (
  input  logic [1:0]  color_depth_i,
  input  logic [31:0] color_i,
  input  logic [1:0]  x_lsb_i,  // byte lane, 0 is the top byte
  output mem_word_u   mem_o,
  output logic [3:0]  sel_o
);

  always_comb begin
    mem_o.word_v = '0;  // unselected bytes stay zero
    sel_o        = '0;
    case (color_depth_i)
      DEPTH_8: begin
        mem_o.byte_v[~x_lsb_i] = color_i[7:0]; // lane 0 -> byte 3
        sel_o[~x_lsb_i]        = 1'b1;
      end
      DEPTH_16: begin
        // lane 0 takes the upper half, lane 2 the lower
        mem_o.half_v[~x_lsb_i[1]] = color_i[15:0];
        sel_o = x_lsb_i[1] ? 4'b0011 : 4'b1100;
      end
      default: begin
        mem_o.word_v = color_i; // 32 bit and code 3
        sel_o        = 4'b1111;
      end
    endcase
  end

  // each depth writes at least one byte
  always_comb begin
    assert (sel_o != 4'b0000)
      else $error("color_to_memory: empty byte select");
  end

endmodule

// ==== logic/memory_to_color.sv ====
// memory to color lane extraction
// picks the byte, halfword or word at a big endian lane and
// zero extends it, the inverse of color_to_memory
module memory_to_color import gfx_pkg::*; (
  input  logic [1:0]  color_depth_i,
  input  mem_word_u   mem_i,
  input  logic [1:0]  mem_lsb_i,  // byte lane, 0 is the top byte
  output logic [31:0] color_o
);

  always_comb begin
    case (color_depth_i)
      DEPTH_8:  color_o = {24'h0, mem_i.byte_v[~mem_lsb_i]};    // lane 0 -> bits 31..24
      DEPTH_16: color_o = {16'h0, mem_i.half_v[~mem_lsb_i[1]]}; // lane 0 -> upper half
      default:  color_o = mem_i.word_v;                         // 32 bit and code 3
    endcase
  end

endmodule

// ==== logic/frame_mem.sv ====
// framebuffer ram
// single port, byte enabled writes through the byte view,
// read data registered one cycle after the strobe
module frame_mem import gfx_pkg::*; #(
  parameter int MEM_AW = 10 // words = 2**MEM_AW
) (
  input  logic        clk_i,
  input  mem_wr_t     wr_i,
  input  logic        rd_en_i,
  input  logic [15:0] rd_addr_i,
  output mem_word_u   rd_data_o
);

  mem_word_u mem_q [2**MEM_AW]; // contents undefined after reset

  always_ff @(posedge clk_i) begin
    if (wr_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_i.sel[b])
          mem_q[wr_i.addr[MEM_AW-1:0]].byte_v[b] <= wr_i.data.byte_v[b];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i)
      rd_data_o <= mem_q[rd_addr_i[MEM_AW-1:0]]; // holds until the next read
  end

  // single port, the register block never issues both
  a_no_rd_wr: assert property (@(posedge clk_i) !(wr_i.we && rd_en_i));

endmodule

// ==== logic/pixel_unit.sv ====
// pixel access unit top
// apb register block driving the address unit, the two lane
// converters and the byte enabled framebuffer ram
module pixel_unit import gfx_pkg::*; #(
  parameter int MEM_AW = 10 // framebuffer address width
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o
);

  pixel_cfg_t  cfg;        // live configuration
  logic [15:0] word_addr;  // shared by write and read
  logic [1:0]  lane;
  logic [1:0]  rd_lane;    // latched for the returned word
  logic [31:0] color;      // pixel being written
  logic [31:0] pixel;      // pixel being read
  mem_word_u   place_word;
  logic [3:0]  place_sel;
  mem_wr_t     mem_wr;
  logic        rd_en;
  mem_word_u   rd_word;

  pixel_regs pixel_regs_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .cfg_o       (cfg),
    .word_addr_i (word_addr),
    .lane_i      (lane),
    .color_o     (color),
    .mem_word_i  (place_word),
    .sel_i       (place_sel),
    .mem_wr_o    (mem_wr),
    .rd_en_o     (rd_en),
    .rd_lane_o   (rd_lane),
    .pixel_i     (pixel)
  );

  pixel_addr #(.MEM_AW(MEM_AW)) pixel_addr_i (
    .cfg_i       (cfg),
    .word_addr_o (word_addr),
    .lane_o      (lane)
  );

  color_to_memory color_to_memory_i (
    .color_depth_i (cfg.depth),
    .color_i       (color),
    .x_lsb_i       (lane),
    .mem_o         (place_word),
    .sel_o         (place_sel)
  );

  memory_to_color memory_to_color_i (
    .color_depth_i (cfg.depth),
    .mem_i         (rd_word),
    .mem_lsb_i     (rd_lane),
    .color_o       (pixel)
  );

  frame_mem #(.MEM_AW(MEM_AW)) frame_mem_i (
    .clk_i     (clk_i),
    .wr_i      (mem_wr),
    .rd_en_i   (rd_en),
    .rd_addr_i (word_addr),
    .rd_data_o (rd_word)
  );

endmodule

// ==== tests/pixel_model.svh ====
// pixel unit reference model
// lcg stimulus source, address and lane rules of the pixel path,
// and a word model of the framebuffer with big endian lanes
`ifndef PIXEL_MODEL_SVH
`define PIXEL_MODEL_SVH

localparam int MEM_AW    = 10;
localparam int MEM_WORDS = 2 ** MEM_AW;

logic [31:0] lcg_state = 32'h60d0;
logic [31:0] model_mem [MEM_WORDS]; // expected framebuffer words

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// upper bits only, the low lcg bits repeat quickly
function automatic logic [31:0] rand_below(logic [31:0] n);
  return (lcg_next() >> 8) % n;
endfunction

function automatic int pixel_bytes(logic [1:0] depth);
  case (depth)
    DEPTH_8:  return 1;
    DEPTH_16: return 2;
    default:  return 4; // code 3 acts as 32 bit
  endcase
endfunction

function automatic logic [63:0] byte_offset(logic [1:0] depth, logic [15:0] width,
                                            logic [15:0] x, logic [15:0] y);
  logic [63:0] idx;
  idx = 64'(y) * 64'(width) + 64'(x);
  return idx * 64'(pixel_bytes(depth));
endfunction

function automatic int ref_word(logic [1:0] depth, logic [15:0] base, logic [15:0] width,
                                logic [15:0] x, logic [15:0] y);
  logic [63:0] w;
  w = 64'(base) + (byte_offset(depth, width, x, y) >> 2);
  return int'(w % 64'(MEM_WORDS)); // wraps inside the ram
endfunction

function automatic logic [1:0] ref_lane(logic [1:0] depth, logic [15:0] width,
                                        logic [15:0] x, logic [15:0] y);
  logic [63:0] off;
  off = byte_offset(depth, width, x, y);
  return off[1:0];
endfunction

function automatic void model_put(int word, logic [1:0] lane, logic [1:0] depth,
                                  logic [31:0] color);
  int n;
  int pos;
  n = pixel_bytes(depth);
  for (int i = 0; i < n; i++) begin
    pos = 3 - (int'(lane) + i); // lane 0 holds bits 31..24
    model_mem[word][pos*8 +: 8] = color[(n-1-i)*8 +: 8];
  end
endfunction

function automatic logic [31:0] model_get(int word, logic [1:0] lane, logic [1:0] depth);
  logic [31:0] v;
  int n;
  int pos;
  v = '0;
  n = pixel_bytes(depth);
  for (int i = 0; i < n; i++) begin
    pos = 3 - (int'(lane) + i);
    v = {v[23:0], model_mem[word][pos*8 +: 8]}; // first lane ends up on top
  end
  return v;
endfunction

// odd multiplier, so every word of the ram gets its own value
function automatic logic [31:0] fill_word(int a);
  return 32'(a) * 32'h9e37_79b1 + 32'h0f0f_1234;
endfunction

`endif

// ==== tests/pixel_unit_tb.sv ====
// pixel unit testbench
// apb traffic over all depths, lane packing and auto increment,
// with every pixel read checked against the framebuffer model
module pixel_unit_tb import gfx_pkg::*; ();

  `include "pixel_model.svh"

  logic        clk_i = 1'b0;
  logic        reset_i;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  int          errors;
  int          checks;
  logic [2:0]  sh_ctrl;  // shadow of the live config
  logic [15:0] sh_base;
  logic [15:0] sh_width;
  logic [15:0] sh_x;
  logic [15:0] sh_y;
  logic [31:0] pos_q [$]; // positions written in the current round
  logic [31:0] seq_q [$];

  pixel_unit #(.MEM_AW(MEM_AW)) pixel_unit_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  always #20 clk_i = ~clk_i;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // setup cycle, then access cycles until pready, sampled mid cycle
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waits;
    int exp_waits;
    exp_waits = (!wr && addr == REG_PIXEL) ? 2 : 1; // pixel read has one wait state
    @(posedge clk_i);
    apb_req.paddr   <= addr;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.pwdata  <= wdata;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    waits = 0;
    do begin
      @(negedge clk_i);
      waits++;
    end while (!apb_rsp.pready && waits < 10);
    if (!apb_rsp.pready) begin
      errors++;
      $display("timeout: no pready within 10 cycles at offset 0x%02h", addr);
      end_run();
    end else begin
      check_eq("pready cycle", 32'(waits), 32'(exp_waits));
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk_i);           // completing edge
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_eq("pslverr", {31'h0, err}, 32'h0);
    case (addr)
      REG_CTRL:  sh_ctrl  = data[2:0];
      REG_BASE:  sh_base  = data[15:0];
      REG_WIDTH: sh_width = data[15:0];
      REG_POS: begin
        sh_x = data[15:0];
        sh_y = data[31:16];
      end
      default: ;
    endcase
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'h0, data, err);
    check_eq("pslverr", {31'h0, err}, 32'h0);
  endtask

  task automatic check_regs();
    logic [31:0] rd;
    read_reg(REG_CTRL, rd);
    check_eq("ctrl", rd, {29'h0, sh_ctrl}); // only 3 bits kept
    read_reg(REG_BASE, rd);
    check_eq("base", rd, {16'h0, sh_base});
    read_reg(REG_WIDTH, rd);
    check_eq("width", rd, {16'h0, sh_width});
    read_reg(REG_POS, rd);
    check_eq("pos", rd, {sh_y, sh_x});
  endtask

  task automatic pixel_write(input logic [31:0] color);
    int         w;
    logic [1:0] l;
    w = ref_word(sh_ctrl[1:0], sh_base, sh_width, sh_x, sh_y);
    l = ref_lane(sh_ctrl[1:0], sh_width, sh_x, sh_y);
    model_put(w, l, sh_ctrl[1:0], color);
    write_reg(REG_PIXEL, color);
    if (sh_ctrl[2]) begin
      sh_x = sh_x + 16'd1; // auto increment
    end
  endtask

  task automatic pixel_read(output logic [31:0] got);
    int         w;
    logic [1:0] l;
    w = ref_word(sh_ctrl[1:0], sh_base, sh_width, sh_x, sh_y);
    l = ref_lane(sh_ctrl[1:0], sh_width, sh_x, sh_y);
    read_reg(REG_PIXEL, got);
    check_eq("prdata", got, model_get(w, l, sh_ctrl[1:0]));
    if (sh_ctrl[2]) begin
      sh_x = sh_x + 16'd1;
    end
  endtask

  // whole word at 32 bit depth, base 0 and row 0
  task automatic read_word_at(input int word, output logic [31:0] got);
    write_reg(REG_CTRL, 32'(DEPTH_32));
    write_reg(REG_BASE, 32'h0);
    write_reg(REG_POS, {16'h0, 16'(word)});
    pixel_read(got);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [15:0] x;
    logic [15:0] y;
    logic [31:0] b;
    int          word;
    reset_i  <= 1'b1;
    apb_req  <= '0;
    errors   = 0;
    checks   = 0;
    sh_ctrl  = '0;
    sh_base  = '0;
    sh_width = '0;
    sh_x     = '0;
    sh_y     = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // registers come up zero, then hold what was written
    check_regs();
    for (int i = 0; i < 8; i++) begin
      write_reg(REG_CTRL, lcg_next());
      write_reg(REG_BASE, lcg_next());
      write_reg(REG_WIDTH, lcg_next());
      write_reg(REG_POS, lcg_next());
      check_regs();
    end

    // known contents everywhere, one auto incremented run over the ram
    write_reg(REG_CTRL, 32'(DEPTH_32) | 32'h4);
    write_reg(REG_BASE, 32'h0);
    write_reg(REG_WIDTH, 32'h0);
    write_reg(REG_POS, 32'h0);
    for (int a = 0; a < MEM_WORDS; a++) begin
      pixel_write(fill_word(a));
    end

    // random writes then reads of written spots, per depth
    for (int d = 0; d < 3; d++) begin
      write_reg(REG_CTRL, d);
      write_reg(REG_BASE, rand_below(MEM_WORDS));
      write_reg(REG_WIDTH, 32'd1 + rand_below(64));
      pos_q.delete();
      for (int i = 0; i < 200; i++) begin
        x = 16'(rand_below({16'h0, sh_width}));
        y = 16'(rand_below(32));
        write_reg(REG_POS, {y, x});
        pixel_write(lcg_next());
        pos_q.push_back({y, x});
      end
      for (int i = 0; i < 100; i++) begin
        write_reg(REG_POS, pos_q[rand_below(pos_q.size())]);
        pixel_read(rd);
      end
    end

    // four bytes into one word come back big endian
    write_reg(REG_CTRL, 32'(DEPTH_8));
    write_reg(REG_BASE, 32'h0);
    write_reg(REG_WIDTH, 32'd64);
    y = 16'(rand_below(8));
    x = 16'(rand_below(16) * 4);
    b = lcg_next();
    for (int i = 0; i < 4; i++) begin
      write_reg(REG_POS, {y, x + 16'(i)});
      pixel_write({24'h0, b[31 - 8*i -: 8]});
    end
    word = (int'(y) * 64 + int'(x)) / 4;
    read_word_at(word, rd);
    check_eq("prdata", rd, b);

    // partial writes leave the other bytes alone
    write_reg(REG_CTRL, 32'(DEPTH_16));
    y = 16'(rand_below(8));
    x = 16'(rand_below(32) * 2 + 1); // odd pixel is lane 2
    write_reg(REG_POS, {y, x});
    pixel_write(lcg_next());
    read_word_at(ref_word(DEPTH_16, 16'h0, 16'd64, x, y), rd);
    write_reg(REG_CTRL, 32'(DEPTH_8));
    write_reg(REG_WIDTH, 32'd64);
    x = 16'(rand_below(16) * 4 + 1); // lane 1
    write_reg(REG_POS, {y, x});
    pixel_write(lcg_next());
    read_word_at(ref_word(DEPTH_8, 16'h0, 16'd64, x, y), rd);

    // auto increment run of writes and reads
    write_reg(REG_CTRL, 32'(DEPTH_16) | 32'h4);
    write_reg(REG_BASE, rand_below(MEM_WORDS));
    write_reg(REG_WIDTH, 32'd200);
    x = 16'(rand_below(100));
    y = 16'(rand_below(8));
    write_reg(REG_POS, {y, x});
    for (int i = 0; i < 16; i++) begin
      seq_q.push_back(lcg_next());
      pixel_write(seq_q[i]);
    end
    write_reg(REG_POS, {y, x});
    for (int i = 0; i < 16; i++) begin
      pixel_read(rd);
      check_eq("prdata", rd, seq_q[i] & 32'h0000_ffff);
    end
    read_reg(REG_POS, rd);
    check_eq("pos", rd, {y, x + 16'd16}); // 16 reads since the pos write

    // unmapped offsets
    apb_xfer(1'b1, 8'h14, lcg_next(), rd, err);
    check_eq("pslverr", {31'h0, err}, 32'h1);
    apb_xfer(1'b1, 8'h11, lcg_next(), rd, err);
    check_eq("pslverr", {31'h0, err}, 32'h1);
    apb_xfer(1'b0, 8'h20, 32'h0, rd, err);
    check_eq("pslverr", {31'h0, err}, 32'h1);
    check_eq("prdata", rd, 32'h0);
    check_regs();
    for (int i = 0; i < 20; i++) begin
      read_word_at(int'(rand_below(MEM_WORDS)), rd);
    end

    end_run();
  end

endmodule

// ==== all.f ====
+incdir+tests
logic/gfx_pkg.sv
logic/pixel_regs.sv
logic/pixel_addr.sv
logic/color_to_memory.sv
logic/memory_to_color.sv
logic/frame_mem.sv
logic/pixel_unit.sv
tests/pixel_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the pixel unit testbench with verilator, runs it and scans the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -f all.f --top-module pixel_unit_tb -o pixel_unit_sim

./obj_dir/pixel_unit_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without a reported failure"
exit 0
